// File: hw/exe_pkg.sv
/* Execute block definitions */

package exe_pkg;

  // datapath and instruction widths
  localparam int XLEN     = 64;
  localparam int ILEN     = 32;
  localparam int RIDX_W   = 5;
  localparam int OPCODE_W = 7;
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;

  // major opcodes handled or forwarded by execute
  localparam logic [OPCODE_W-1:0] OPC_OP      = 7'b0110011;
  localparam logic [OPCODE_W-1:0] OPC_OPIMM   = 7'b0010011;
  localparam logic [OPCODE_W-1:0] OPC_OP32    = 7'b0111011;
  localparam logic [OPCODE_W-1:0] OPC_OPIMM32 = 7'b0011011;
  localparam logic [OPCODE_W-1:0] OPC_LUI     = 7'b0110111;
  localparam logic [OPCODE_W-1:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [OPCODE_W-1:0] OPC_JAL     = 7'b1101111;
  localparam logic [OPCODE_W-1:0] OPC_JALR    = 7'b1100111;
  localparam logic [OPCODE_W-1:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [OPCODE_W-1:0] OPC_LOAD    = 7'b0000011;
  localparam logic [OPCODE_W-1:0] OPC_STORE   = 7'b0100011;

  // integer funct3 codes, shared by register and immediate forms
  localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
  localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
  localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_SR   = 3'b101; // srl or sra by funct7 bit 5
  localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

  // branch conditions
  localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
  localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
  localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
  localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
  localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
  localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

  // memory stage action codes
  localparam int MEMACT_W = 2;
  localparam logic [MEMACT_W-1:0] MEMACT_NONE  = 2'd0;
  localparam logic [MEMACT_W-1:0] MEMACT_LOAD  = 2'd1;
  localparam logic [MEMACT_W-1:0] MEMACT_STORE = 2'd2;

endpackage

// File: hw/exe_alu.sv
/* Integer ALU */

`timescale 1ns/100ps

module exe_alu
  import exe_pkg::*;
(
  input  logic [OPCODE_W-1:0] i_opcode,
  input  logic [FUNCT3_W-1:0] i_funct3,
  input  logic [FUNCT7_W-1:0] i_funct7,
  input  logic [XLEN-1:0]     i_op1,
  input  logic [XLEN-1:0]     i_op2,
  input  logic [XLEN-1:0]     i_pc,
  output logic                o_rd_wen,
  output logic [XLEN-1:0]     o_rd_wdata
);

  logic            reg_form;
  logic            do_sub;
  logic            do_sra;
  logic [5:0]      shamt;
  logic [4:0]      shamt_w;
  logic [31:0]     op1_w;
  logic [31:0]     op2_w;
  logic [XLEN-1:0] res64;
  logic [31:0]     res32;

  assign reg_form = (i_opcode == OPC_OP) || (i_opcode == OPC_OP32);
  assign do_sub   = reg_form && i_funct7[5]; // immediate forms never subtract
  assign do_sra   = i_funct7[5]; // srai also carries this bit in the immediate
  assign shamt    = i_op2[5:0];
  assign shamt_w  = i_op2[4:0];
  assign op1_w    = i_op1[31:0];
  assign op2_w    = i_op2[31:0];

  always_comb begin
    res64 = '0;
    case (i_funct3)
      F3_ADD:  res64 = do_sub ? i_op1 - i_op2 : i_op1 + i_op2;
      F3_SLL:  res64 = i_op1 << shamt;
      F3_SLT:  res64 = {{(XLEN-1){1'b0}}, $signed(i_op1) < $signed(i_op2)};
      F3_SLTU: res64 = {{(XLEN-1){1'b0}}, i_op1 < i_op2};
      F3_XOR:  res64 = i_op1 ^ i_op2;
      F3_SR: begin
        if (do_sra) begin
          res64 = $signed(i_op1) >>> shamt;
        end else begin
          res64 = i_op1 >> shamt;
        end
      end
      F3_OR:   res64 = i_op1 | i_op2;
      F3_AND:  res64 = i_op1 & i_op2;
      default: res64 = '0;
    endcase
  end

  // word forms only define add/sub and the shifts
  always_comb begin
    res32 = '0;
    case (i_funct3)
      F3_ADD: res32 = do_sub ? op1_w - op2_w : op1_w + op2_w;
      F3_SLL: res32 = op1_w << shamt_w;
      F3_SR: begin
        if (do_sra) begin
          res32 = $signed(op1_w) >>> shamt_w;
        end else begin
          res32 = op1_w >> shamt_w;
        end
      end
      default: res32 = '0;
    endcase
  end

  always_comb begin
    o_rd_wen   = 1'b1;
    o_rd_wdata = '0;
    case (i_opcode)
      OPC_OP, OPC_OPIMM:     o_rd_wdata = res64;
      OPC_OP32, OPC_OPIMM32: o_rd_wdata = {{(XLEN-32){res32[31]}}, res32};
      OPC_LUI:               o_rd_wdata = i_op2; // decode already shifted the immediate
      OPC_AUIPC:             o_rd_wdata = i_pc + i_op2;
      OPC_JAL, OPC_JALR:     o_rd_wdata = i_pc + XLEN'(4); // link address
      default: begin
        o_rd_wen   = 1'b0;
        o_rd_wdata = '0;
      end
    endcase
  end

endmodule

// File: hw/exe_branch.sv
/* Branch and jump resolver */

`timescale 1ns/100ps

module exe_branch
  import exe_pkg::*;
(
  input  logic [OPCODE_W-1:0] i_opcode,
  input  logic [FUNCT3_W-1:0] i_funct3,
  input  logic [XLEN-1:0]     i_op1,
  input  logic [XLEN-1:0]     i_op2,
  input  logic [XLEN-1:0]     i_t1,
  input  logic [XLEN-1:0]     i_pc,
  input  logic [XLEN-1:0]     i_pc_pred,
  output logic                o_pc_jmp,
  output logic [XLEN-1:0]     o_pc_jmpaddr
);

  logic            is_eq;
  logic            is_lt;
  logic            is_ltu;
  logic            taken;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] pc_next;

  assign is_eq    = (i_op1 == i_op2);
  assign is_lt    = ($signed(i_op1) < $signed(i_op2));
  assign is_ltu   = (i_op1 < i_op2);
  assign jalr_sum = i_op1 + i_t1;

  always_comb begin
    case (i_funct3)
      F3_BEQ:  taken = is_eq;
      F3_BNE:  taken = !is_eq;
      F3_BLT:  taken = is_lt;
      F3_BGE:  taken = !is_lt;
      F3_BLTU: taken = is_ltu;
      F3_BGEU: taken = !is_ltu;
      default: taken = 1'b0; // reserved encodings fall through
    endcase
  end

  always_comb begin
    if (i_opcode == OPC_JAL) begin
      pc_next = i_pc + i_t1;
    end else if (i_opcode == OPC_JALR) begin
      pc_next = {jalr_sum[XLEN-1:1], 1'b0};
    end else if ((i_opcode == OPC_BRANCH) && taken) begin
      pc_next = i_pc + i_t1;
    end else begin
      pc_next = i_pc + XLEN'(4);
    end
  end

  // fetch only needs redirecting when the prediction was wrong
  assign o_pc_jmp     = (pc_next != i_pc_pred);
  assign o_pc_jmpaddr = pc_next;

endmodule

// File: hw/exe_stage.sv
/* Execute stage register */

`timescale 1ns/100ps

module exe_stage
  import exe_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                i_decoded_req,
  output logic                o_decoded_ack,
  output logic                o_executed_req,
  input  logic                i_executed_ack,
  input  logic [XLEN-1:0]     i_pc,
  input  logic [ILEN-1:0]     i_inst,
  input  logic [OPCODE_W-1:0] i_opcode,
  input  logic [FUNCT3_W-1:0] i_funct3,
  input  logic [FUNCT7_W-1:0] i_funct7,
  input  logic [XLEN-1:0]     i_op1,
  input  logic [XLEN-1:0]     i_op2,
  input  logic [XLEN-1:0]     i_t1,
  input  logic [XLEN-1:0]     i_memaddr,
  input  logic [RIDX_W-1:0]   i_rd,
  input  logic [XLEN-1:0]     i_pc_pred,
  input  logic                i_nocmt,
  input  logic                i_skipcmt,
  output logic [OPCODE_W-1:0] o_opcode,
  output logic [FUNCT3_W-1:0] o_funct3,
  output logic [FUNCT7_W-1:0] o_funct7,
  output logic [XLEN-1:0]     o_op1,
  output logic [XLEN-1:0]     o_op2,
  output logic [XLEN-1:0]     o_t1,
  output logic [XLEN-1:0]     o_pc,
  output logic [XLEN-1:0]     o_pc_pred,
  output logic [XLEN-1:0]     o_ex_pc,
  output logic [ILEN-1:0]     o_ex_inst,
  output logic [RIDX_W-1:0]   o_ex_rd,
  output logic [XLEN-1:0]     o_ex_memaddr,
  output logic                o_ex_memren,
  output logic                o_ex_memwen,
  output logic [MEMACT_W-1:0] o_ex_memaction,
  output logic                o_ex_nocmt,
  output logic                o_ex_skipcmt
);

  logic                valid;
  logic                decoded_hs;
  logic                executed_hs;
  logic [ILEN-1:0]     inst_q;
  logic [XLEN-1:0]     memaddr_q;
  logic [RIDX_W-1:0]   rd_q;
  logic                nocmt_q;
  logic                skipcmt_q;
  logic                is_load;
  logic                is_store;

  // a held record leaving this cycle frees the slot for the next one
  assign o_decoded_ack  = !valid || i_executed_ack;
  assign o_executed_req = valid;
  assign decoded_hs     = i_decoded_req && o_decoded_ack;
  assign executed_hs    = valid && i_executed_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (decoded_hs) begin
      valid <= 1'b1;
    end else if (executed_hs) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (decoded_hs) begin
      o_pc      <= i_pc;
      inst_q    <= i_inst;
      o_opcode  <= i_opcode;
      o_funct3  <= i_funct3;
      o_funct7  <= i_funct7;
      o_op1     <= i_op1;
      o_op2     <= i_op2;
      o_t1      <= i_t1;
      memaddr_q <= i_memaddr;
      rd_q      <= i_rd;
      o_pc_pred <= i_pc_pred;
      nocmt_q   <= i_nocmt;
      skipcmt_q <= i_skipcmt;
    end
  end

  assign is_load  = (o_opcode == OPC_LOAD);
  assign is_store = (o_opcode == OPC_STORE);

  // the memory side sees only zeros while the stage is empty
  assign o_ex_pc      = valid ? o_pc : '0;
  assign o_ex_inst    = valid ? inst_q : '0;
  assign o_ex_rd      = valid ? rd_q : '0;
  assign o_ex_memaddr = valid ? memaddr_q : '0;
  assign o_ex_memren  = valid && is_load;
  assign o_ex_memwen  = valid && is_store;
  assign o_ex_nocmt   = valid && nocmt_q;
  assign o_ex_skipcmt = valid && skipcmt_q;

  always_comb begin
    if (o_ex_memren) begin
      o_ex_memaction = MEMACT_LOAD;
    end else if (o_ex_memwen) begin
      o_ex_memaction = MEMACT_STORE;
    end else begin
      o_ex_memaction = MEMACT_NONE;
    end
  end

endmodule

// File: hw/exe_top.sv
/* Execute block top */

`timescale 1ns/100ps

module exe_top
  import exe_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                i_decoded_req,
  output logic                o_decoded_ack,
  output logic                o_executed_req,
  input  logic                i_executed_ack,
  input  logic [XLEN-1:0]     i_pc,
  input  logic [ILEN-1:0]     i_inst,
  input  logic [OPCODE_W-1:0] i_opcode,
  input  logic [FUNCT3_W-1:0] i_funct3,
  input  logic [FUNCT7_W-1:0] i_funct7,
  input  logic [XLEN-1:0]     i_op1,
  input  logic [XLEN-1:0]     i_op2,
  input  logic [XLEN-1:0]     i_t1,
  input  logic [XLEN-1:0]     i_memaddr,
  input  logic [RIDX_W-1:0]   i_rd,
  input  logic [XLEN-1:0]     i_pc_pred,
  input  logic                i_nocmt,
  input  logic                i_skipcmt,
  output logic [XLEN-1:0]     o_ex_pc,
  output logic [ILEN-1:0]     o_ex_inst,
  output logic [RIDX_W-1:0]   o_ex_rd,
  output logic [XLEN-1:0]     o_ex_memaddr,
  output logic                o_ex_memren,
  output logic                o_ex_memwen,
  output logic [MEMACT_W-1:0] o_ex_memaction,
  output logic                o_ex_nocmt,
  output logic                o_ex_skipcmt,
  output logic                o_pc_jmp,
  output logic [XLEN-1:0]     o_pc_jmpaddr,
  output logic                o_rd_wen,
  output logic [XLEN-1:0]     o_rd_wdata
);

  logic [OPCODE_W-1:0] ex_opcode;
  logic [FUNCT3_W-1:0] ex_funct3;
  logic [FUNCT7_W-1:0] ex_funct7;
  logic [XLEN-1:0]     ex_op1;
  logic [XLEN-1:0]     ex_op2;
  logic [XLEN-1:0]     ex_t1;
  logic [XLEN-1:0]     ex_pc;
  logic [XLEN-1:0]     ex_pc_pred;
  logic                alu_rd_wen;
  logic [XLEN-1:0]     alu_rd_wdata;
  logic                br_pc_jmp;
  logic [XLEN-1:0]     br_pc_jmpaddr;

  // handshake and memory-side ports share names with the top
  exe_stage u_stage (
    .*,
    .o_opcode  (ex_opcode),
    .o_funct3  (ex_funct3),
    .o_funct7  (ex_funct7),
    .o_op1     (ex_op1),
    .o_op2     (ex_op2),
    .o_t1      (ex_t1),
    .o_pc      (ex_pc),
    .o_pc_pred (ex_pc_pred)
  );

  exe_alu u_alu (
    .i_opcode   (ex_opcode),
    .i_funct3   (ex_funct3),
    .i_funct7   (ex_funct7),
    .i_op1      (ex_op1),
    .i_op2      (ex_op2),
    .i_pc       (ex_pc),
    .o_rd_wen   (alu_rd_wen),
    .o_rd_wdata (alu_rd_wdata)
  );

  exe_branch u_branch (
    .i_opcode     (ex_opcode),
    .i_funct3     (ex_funct3),
    .i_op1        (ex_op1),
    .i_op2        (ex_op2),
    .i_t1         (ex_t1),
    .i_pc         (ex_pc),
    .i_pc_pred    (ex_pc_pred),
    .o_pc_jmp     (br_pc_jmp),
    .o_pc_jmpaddr (br_pc_jmpaddr)
  );

  // results only mean something while a record is held
  assign o_rd_wen     = o_executed_req && alu_rd_wen;
  assign o_rd_wdata   = o_executed_req ? alu_rd_wdata : '0;
  assign o_pc_jmp     = o_executed_req && br_pc_jmp;
  assign o_pc_jmpaddr = o_executed_req ? br_pc_jmpaddr : '0;

endmodule

// File: tests/exe_top_tb.sv
/* Execute block testbench */

`timescale 1ns/100ps

module exe_top_tb
  import exe_pkg::*;
();

  localparam int TIMEOUT = 100;
  localparam logic [OPCODE_W-1:0] OPCS [11] = '{OPC_OP, OPC_OPIMM, OPC_OP32, OPC_OPIMM32,
    OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE};

  typedef struct packed {
    logic [XLEN-1:0]     pc;
    logic [ILEN-1:0]     inst;
    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic [FUNCT7_W-1:0] funct7;
    logic [XLEN-1:0]     op1;
    logic [XLEN-1:0]     op2;
    logic [XLEN-1:0]     t1;
    logic [XLEN-1:0]     memaddr;
    logic [RIDX_W-1:0]   rd;
    logic [XLEN-1:0]     pc_pred;
    logic                nocmt;
    logic                skipcmt;
  } instr_t;

  typedef struct packed {
    logic                rd_wen;
    logic [XLEN-1:0]     rd_wdata;
    logic                jmp;
    logic [XLEN-1:0]     jmpaddr;
    logic                memren;
    logic                memwen;
    logic [MEMACT_W-1:0] memact;
  } exp_t;

  logic                clk = 1'b0;
  logic                rst = 1'b1;
  logic                i_decoded_req = 1'b0;
  logic                i_executed_ack = 1'b1;
  instr_t              drv = '0;
  logic                o_decoded_ack;
  logic                o_executed_req;
  logic                o_ex_memren;
  logic                o_ex_memwen;
  logic                o_ex_nocmt;
  logic                o_ex_skipcmt;
  logic                o_pc_jmp;
  logic                o_rd_wen;
  logic [XLEN-1:0]     o_ex_pc;
  logic [XLEN-1:0]     o_ex_memaddr;
  logic [XLEN-1:0]     o_pc_jmpaddr;
  logic [XLEN-1:0]     o_rd_wdata;
  logic [ILEN-1:0]     o_ex_inst;
  logic [RIDX_W-1:0]   o_ex_rd;
  logic [MEMACT_W-1:0] o_ex_memaction;
  integer              seed = 94159;
  logic                stall_mode = 1'b0;
  logic                held = 1'b0;
  logic                lat_pend = 1'b0;
  logic [XLEN-1:0]     last_wdata = '0;
  logic [XLEN-1:0]     last_jmpaddr = '0;
  instr_t              sent_q [$];

  exe_top uut (
    .*,
    .i_pc      (drv.pc),
    .i_inst    (drv.inst),
    .i_opcode  (drv.opcode),
    .i_funct3  (drv.funct3),
    .i_funct7  (drv.funct7),
    .i_op1     (drv.op1),
    .i_op2     (drv.op2),
    .i_t1      (drv.t1),
    .i_memaddr (drv.memaddr),
    .i_rd      (drv.rd),
    .i_pc_pred (drv.pc_pred),
    .i_nocmt   (drv.nocmt),
    .i_skipcmt (drv.skipcmt)
  );

  always #50 clk = ~clk;

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_ridx(input logic [RIDX_W-1:0] got, input logic [RIDX_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      fail_run($sformatf("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  function automatic exp_t exe_model(input instr_t x);
    exp_t        e;
    logic [31:0] w;
    logic        sub;
    logic        tk;
    e = '0;
    e.rd_wen = 1'b1;
    sub = x.funct7[5] && (x.opcode == OPC_OP || x.opcode == OPC_OP32); // register forms only
    case (x.opcode)
      OPC_OP, OPC_OPIMM: begin
        case (x.funct3)
          F3_ADD:  e.rd_wdata = sub ? x.op1 - x.op2 : x.op1 + x.op2;
          F3_SLL:  e.rd_wdata = x.op1 << x.op2[5:0];
          F3_SLT:  e.rd_wdata = XLEN'($signed(x.op1) < $signed(x.op2));
          F3_SLTU: e.rd_wdata = XLEN'(x.op1 < x.op2);
          F3_XOR:  e.rd_wdata = x.op1 ^ x.op2;
          F3_SR:   e.rd_wdata = x.funct7[5] ? $unsigned($signed(x.op1) >>> x.op2[5:0])
                                            : x.op1 >> x.op2[5:0];
          F3_OR:   e.rd_wdata = x.op1 | x.op2;
          default: e.rd_wdata = x.op1 & x.op2;
        endcase
      end
      OPC_OP32, OPC_OPIMM32: begin
        case (x.funct3)
          F3_SLL:  w = x.op1[31:0] << x.op2[4:0];
          F3_SR:   w = x.funct7[5] ? $unsigned($signed(x.op1[31:0]) >>> x.op2[4:0])
                                   : x.op1[31:0] >> x.op2[4:0];
          default: w = sub ? x.op1[31:0] - x.op2[31:0] : x.op1[31:0] + x.op2[31:0];
        endcase
        e.rd_wdata = {{(XLEN-32){w[31]}}, w};
      end
      OPC_LUI:           e.rd_wdata = x.op2;
      OPC_AUIPC:         e.rd_wdata = x.pc + x.op2;
      OPC_JAL, OPC_JALR: e.rd_wdata = x.pc + XLEN'(4);
      default:           e.rd_wen = 1'b0;
    endcase
    case (x.funct3)
      F3_BEQ:  tk = x.op1 == x.op2;
      F3_BNE:  tk = x.op1 != x.op2;
      F3_BLT:  tk = $signed(x.op1) < $signed(x.op2);
      F3_BGE:  tk = $signed(x.op1) >= $signed(x.op2);
      F3_BLTU: tk = x.op1 < x.op2;
      default: tk = x.op1 >= x.op2;
    endcase
    if (x.opcode == OPC_JAL || (x.opcode == OPC_BRANCH && tk)) begin
      e.jmpaddr = x.pc + x.t1;
    end else if (x.opcode == OPC_JALR) begin
      e.jmpaddr = (x.op1 + x.t1) & ~XLEN'(1);
    end else begin
      e.jmpaddr = x.pc + XLEN'(4);
    end
    e.jmp = e.jmpaddr != x.pc_pred;
    e.memren = x.opcode == OPC_LOAD;
    e.memwen = x.opcode == OPC_STORE;
    e.memact = e.memren ? MEMACT_LOAD : (e.memwen ? MEMACT_STORE : MEMACT_NONE);
    return e;
  endfunction

  function automatic logic [XLEN-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // sends count random instructions drawn from OPCS[first +: span]
  task automatic run_group(input int first, input int span, input int count);
    instr_t      x;
    logic [31:0] pick;
    logic [3:0]  idx;
    int          n;
    repeat (count) begin
      pick = $random(seed);
      idx = 4'(first + int'(pick[31:24]) % span);
      x.opcode = OPCS[idx];
      x.pc = rand64() & ~XLEN'(3);
      x.inst = $random(seed);
      x.funct3 = pick[2:0];
      x.funct7 = {1'b0, pick[3], 5'b0};
      x.op1 = rand64();
      x.op2 = (x.inst[2] && x.inst[3]) ? x.op1 : rand64(); // equal compares now and then
      x.t1 = XLEN'($signed(pick[23:12]));
      x.memaddr = rand64();
      x.rd = pick[9:5];
      x.nocmt = pick[10];
      x.skipcmt = pick[11];
      x.pc_pred = x.inst[0] ? x.pc + x.t1 : x.pc + XLEN'(4);
      if (x.opcode == OPC_OP32 || x.opcode == OPC_OPIMM32) begin
        x.funct3 = pick[1] ? F3_ADD : (pick[0] ? F3_SLL : F3_SR);
      end else if (x.opcode == OPC_BRANCH && x.funct3[2:1] == 2'b01) begin
        x.funct3 = F3_BEQ; // funct3 values 2 and 3 encode no branch
      end else if (x.opcode == OPC_JALR && x.inst[1]) begin
        x.op1 = x.pc;
      end
      i_decoded_req <= 1'b1;
      drv <= x;
      n = 0;
      @(negedge clk);
      while (!o_decoded_ack) begin
        n++;
        if (n > TIMEOUT) begin
          fail_run("timed out waiting for the DUT to accept an instruction");
        end
        @(negedge clk);
      end
      @(posedge clk);
    end
  endtask

  task automatic compare_result();
    instr_t x;
    exp_t   e;
    if (sent_q.size() == 0) begin
      fail_run("the DUT presented a result with no instruction outstanding");
    end
    x = sent_q.pop_front();
    e = exe_model(x);
    check_flag(o_rd_wen, e.rd_wen, "rd_wen");
    check_data(o_rd_wdata, e.rd_wdata, "rd_wdata");
    check_flag(o_pc_jmp, e.jmp, "pc_jmp");
    check_data(o_pc_jmpaddr, e.jmpaddr, "pc_jmpaddr");
    check_flag(o_ex_memren, e.memren, "memren");
    check_flag(o_ex_memwen, e.memwen, "memwen");
    check_flag(o_ex_memaction == e.memact, 1'b1, "memaction matches");
    check_data(o_ex_memaddr, x.memaddr, "memaddr");
    check_data(o_ex_pc, x.pc, "ex_pc");
    check_data(XLEN'(o_ex_inst), XLEN'(x.inst), "ex_inst");
    check_ridx(o_ex_rd, x.rd, "ex_rd");
    check_flag(o_ex_nocmt, x.nocmt, "nocmt");
    check_flag(o_ex_skipcmt, x.skipcmt, "skipcmt");
  endtask

  always @(posedge clk) begin
    i_executed_ack <= stall_mode ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // everything is sampled mid-cycle, where the next rising edge will see it
  always @(negedge clk) begin
    if (!rst) begin
      if (lat_pend) begin
        check_flag(o_executed_req, 1'b1, "executed req one cycle after accept");
      end
      if (held) begin
        check_flag(o_executed_req, 1'b1, "executed req while stalled");
        check_data(o_rd_wdata, last_wdata, "rd_wdata while stalled");
        check_data(o_pc_jmpaddr, last_jmpaddr, "pc_jmpaddr while stalled");
      end
      if (o_executed_req && !i_executed_ack) begin
        check_flag(o_decoded_ack, 1'b0, "decoded ack while stalled");
      end
      if (!o_executed_req) begin
        check_flag(o_rd_wen || o_pc_jmp || o_ex_memren || o_ex_memwen || o_ex_nocmt
                   || o_ex_skipcmt || (|o_ex_memaction), 1'b0, "result flags while empty");
        check_data(o_rd_wdata | o_pc_jmpaddr | o_ex_pc | o_ex_memaddr | XLEN'(o_ex_inst),
                   '0, "result data while empty");
        check_ridx(o_ex_rd, '0, "ex_rd while empty");
      end
      if (o_executed_req && i_executed_ack) begin
        compare_result();
      end
      held = o_executed_req && !i_executed_ack;
      last_wdata = o_rd_wdata;
      last_jmpaddr = o_pc_jmpaddr;
      lat_pend = i_decoded_req && o_decoded_ack;
      if (lat_pend) begin
        sent_q.push_back(drv);
      end
    end
  end

  initial begin
    int n;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_flag(o_executed_req, 1'b0, "executed req after reset");
    check_flag(o_decoded_ack, 1'b1, "decoded ack after reset");
    check_data(o_rd_wdata, '0, "rd_wdata after reset");
    @(posedge clk);
    run_group(0, 4, 120);  // back-to-back integer ops
    run_group(4, 4, 60);   // lui, auipc, jal, jalr
    run_group(8, 1, 60);
    run_group(9, 2, 40);
    stall_mode <= 1'b1;
    run_group(0, 11, 250);
    i_decoded_req <= 1'b0;
    n = 0;
    while (sent_q.size() != 0) begin
      n++;
      if (n > TIMEOUT) begin
        fail_run("timed out waiting for the last results to leave the DUT");
      end
      @(negedge clk);
    end
    @(negedge clk);
    check_flag(o_executed_req, 1'b0, "executed req after the last transfer");
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: exe_top.f
hw/exe_pkg.sv
hw/exe_alu.sv
hw/exe_branch.sv
hw/exe_stage.sv
hw/exe_top.sv
tests/exe_top_tb.sv

// File: Makefile
SIM       := verilator
FLAGS     := --binary --timing -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := exe_top_tb
FILELIST  := exe_top.f

.PHONY: all lint clean

all:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
